// ==== logic/dvp_cfg.svh ====
`ifndef DVP_CFG_SVH
`define DVP_CFG_SVH

// Register word offsets on PADDR
`define DVP_ADDR_VI_CR     3'd0
`define DVP_ADDR_VI_START  3'd1
`define DVP_ADDR_VI_END    3'd2
`define DVP_ADDR_VI_SR     3'd3
`define DVP_ADDR_VP_CR     3'd4
`define DVP_ADDR_VP_SR     3'd5
`define DVP_ADDR_VO_CR     3'd6
`define DVP_ADDR_VO_SR     3'd7

// Frame geometry
`define DVP_FRAME_WIDTH    16  // Pixels per line
`define DVP_FRAME_HEIGHT   8   // Lines per frame

// Counter and coordinate widths
`define DVP_COORD_W        16
`define DVP_FRAME_CNT_W    16
`define DVP_PIXEL_CNT_W    32

`endif

// ==== logic/dvp_pkg.sv ====
package dvp_pkg;

    // One RGB888 pixel, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgbPixel_t;

    // Input source select, VI_CR[2:1]
    typedef enum logic [1:0] {
        VI_TEST     = 2'd0,
        VI_CAMERA   = 2'd1,
        VI_HDMI     = 2'd2,  // No pixels produced
        VI_RESERVED = 2'd3
    } viMode_e;

    // Processing select, VP_CR[2:1]
    typedef enum logic [1:0] {
        VP_BYPASS    = 2'd0,
        VP_THRESHOLD = 2'd1,
        VP_GRAY      = 2'd2,
        VP_RESERVED  = 2'd3  // Behaves as bypass
    } vpMode_e;

endpackage

// ==== logic/AhbDVP.sv ====
`timescale 1ns/1ps
`include "dvp_cfg.svh"

module AhbDVP (
    input  logic                         io_ahb_PCLK,
    input  logic                         io_ahb_PRESET,
    input  logic [2:0]                   io_ahb_PADDR,
    input  logic [0:0]                   io_ahb_PSEL,
    input  logic                         io_ahb_PENABLE,
    output logic                         io_ahb_PREADY,
    input  logic                         io_ahb_PWRITE,
    input  logic [31:0]                  io_ahb_PWDATA,
    output logic [31:0]                  io_ahb_PRDATA,
    output logic                         io_ahb_PSLVERROR,
    // Status from the stages
    input  logic [`DVP_FRAME_CNT_W-1:0]  viFrameCount,
    input  logic [`DVP_PIXEL_CNT_W-1:0]  vpPixelCount,
    input  logic [`DVP_FRAME_CNT_W-1:0]  voFrameCount,
    // Decoded configuration
    output logic                         viEnable,
    output dvp_pkg::viMode_e             viMode,
    output logic                         viCut,
    output logic [31:0]                  viStart,
    output logic [31:0]                  viEnd,
    output logic                         vpEnable,
    output dvp_pkg::vpMode_e             vpMode,
    output logic [7:0]                   vpThreshold,
    output logic                         voEnable
);
    import dvp_pkg::*;

    logic [31:0] viCr;
    logic [31:0] viStartReg;  // {y, x} of the window origin
    logic [31:0] viEndReg;    // {y, x} of the last window pixel
    logic [31:0] vpCr;        // Filter bits kept for readback
    logic [31:0] voCr;        // Mode bits kept for readback
    logic        wrEn;
    logic        rdEn;

    assign io_ahb_PREADY    = 1'b1;
    assign io_ahb_PSLVERROR = 1'b0;

    assign wrEn = io_ahb_PSEL[0] && io_ahb_PENABLE && io_ahb_PWRITE;
    assign rdEn = io_ahb_PSEL[0] && io_ahb_PENABLE && !io_ahb_PWRITE;

    // Control registers only, status offsets ignore writes
    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            viCr       <= 32'h0;
            viStartReg <= 32'h0;
            viEndReg   <= 32'h0;
            vpCr       <= 32'h0;
            voCr       <= 32'h0;
        end else if (wrEn) begin
            case (io_ahb_PADDR)
                `DVP_ADDR_VI_CR:    viCr       <= io_ahb_PWDATA;
                `DVP_ADDR_VI_START: viStartReg <= io_ahb_PWDATA;
                `DVP_ADDR_VI_END:   viEndReg   <= io_ahb_PWDATA;
                `DVP_ADDR_VP_CR:    vpCr       <= io_ahb_PWDATA;
                `DVP_ADDR_VO_CR:    voCr       <= io_ahb_PWDATA;
                default: ;
            endcase
        end
    end

    always_comb begin
        io_ahb_PRDATA = 32'h0;
        if (rdEn) begin
            case (io_ahb_PADDR)
                `DVP_ADDR_VI_CR:    io_ahb_PRDATA = viCr;
                `DVP_ADDR_VI_START: io_ahb_PRDATA = viStartReg;
                `DVP_ADDR_VI_END:   io_ahb_PRDATA = viEndReg;
                `DVP_ADDR_VI_SR:    io_ahb_PRDATA = 32'(viFrameCount);
                `DVP_ADDR_VP_CR:    io_ahb_PRDATA = vpCr;
                `DVP_ADDR_VP_SR:    io_ahb_PRDATA = 32'(vpPixelCount);
                `DVP_ADDR_VO_CR:    io_ahb_PRDATA = voCr;
                `DVP_ADDR_VO_SR:    io_ahb_PRDATA = 32'(voFrameCount);
                default:            io_ahb_PRDATA = 32'h0;
            endcase
        end
    end

    // Field decode toward the stages
    assign viEnable    = viCr[0];
    assign viMode      = viMode_e'(viCr[2:1]);
    assign viCut       = viCr[3];
    assign viStart     = viStartReg;
    assign viEnd       = viEndReg;

    assign vpEnable    = vpCr[0];
    assign vpMode      = vpMode_e'(vpCr[2:1]);
    assign vpThreshold = vpCr[15:8];

    assign voEnable    = voCr[0];

endmodule

// ==== logic/VideoInput.sv ====
`timescale 1ns/1ps
`include "dvp_cfg.svh"

module VideoInput (
    input  logic                         io_ahb_PCLK,
    input  logic                         io_ahb_PRESET,
    input  logic                         viEnable,
    input  dvp_pkg::viMode_e             viMode,
    input  logic                         viCut,
    input  logic [31:0]                  viStart,
    input  logic [31:0]                  viEnd,
    input  dvp_pkg::rgbPixel_t           camPixel,
    input  logic                         camValid,
    input  logic                         camFrameStart,
    output dvp_pkg::rgbPixel_t           viPixel,
    output logic                         viValid,
    output logic                         viFrameStart,
    output logic [`DVP_FRAME_CNT_W-1:0]  viFrameCount
);
    import dvp_pkg::*;

    localparam logic [`DVP_COORD_W-1:0] lastX = `DVP_COORD_W'(`DVP_FRAME_WIDTH - 1);
    localparam logic [`DVP_COORD_W-1:0] lastY = `DVP_COORD_W'(`DVP_FRAME_HEIGHT - 1);

    logic [`DVP_COORD_W-1:0] xCnt;  // Position of the next pixel
    logic [`DVP_COORD_W-1:0] yCnt;
    logic [`DVP_COORD_W-1:0] pixX;  // Position of the current pixel
    logic [`DVP_COORD_W-1:0] pixY;
    logic                    testMode;
    logic                    active;
    logic                    inValid;
    logic                    newFrame;
    logic                    inWindow;
    logic                    emit;
    logic                    startPending;
    logic                    pendingReg;  // Frame begun but nothing emitted yet
    rgbPixel_t               srcPixel;

    assign testMode = (viMode == VI_TEST);
    assign active   = viEnable && (testMode || viMode == VI_CAMERA);
    assign inValid  = active && (testMode || camValid);  // Generator never idles

    // Camera frame start puts its own pixel at the origin
    assign pixX = (!testMode && camFrameStart) ? '0 : xCnt;
    assign pixY = (!testMode && camFrameStart) ? '0 : yCnt;

    assign newFrame = testMode ? (xCnt == '0 && yCnt == '0) : camFrameStart;

    always_comb begin
        if (testMode) begin
            srcPixel.r = pixX[7:0];
            srcPixel.g = pixY[7:0];
            srcPixel.b = pixX[7:0] ^ pixY[7:0];
        end else begin
            srcPixel = camPixel;
        end
    end

    // Inclusive crop window, x in the low half and y in the high half
    assign inWindow = !viCut ||
                      (pixX >= viStart[15:0]  && pixX <= viEnd[15:0] &&
                       pixY >= viStart[31:16] && pixY <= viEnd[31:16]);

    assign emit         = inValid && inWindow;
    assign startPending = (inValid && newFrame) || pendingReg;

    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            xCnt         <= '0;
            yCnt         <= '0;
            pendingReg   <= 1'b0;
            viValid      <= 1'b0;
            viFrameStart <= 1'b0;
            viFrameCount <= '0;
        end else if (!active) begin
            pendingReg   <= 1'b0;  // Wait for a fresh frame
            viValid      <= 1'b0;
            viFrameStart <= 1'b0;
        end else begin
            if (inValid) begin
                if (pixX == lastX) begin
                    xCnt <= '0;
                    yCnt <= (pixY == lastY) ? '0 : pixY + 1'b1;
                end else begin
                    xCnt <= pixX + 1'b1;
                    yCnt <= pixY;
                end
                pendingReg <= startPending && !emit;
            end
            viValid      <= emit;
            viFrameStart <= emit && startPending;
            if (emit && startPending) begin
                viFrameCount <= viFrameCount + 1'b1;
            end
        end
    end

    always_ff @(posedge io_ahb_PCLK) begin
        viPixel <= srcPixel;
    end

endmodule

// ==== logic/PixelProcess.sv ====
`timescale 1ns/1ps
`include "dvp_cfg.svh"

module PixelProcess (
    input  logic                         io_ahb_PCLK,
    input  logic                         io_ahb_PRESET,
    input  logic                         vpEnable,
    input  dvp_pkg::vpMode_e             vpMode,
    input  logic [7:0]                   vpThreshold,
    input  dvp_pkg::rgbPixel_t           viPixel,
    input  logic                         viValid,
    input  logic                         viFrameStart,
    output dvp_pkg::rgbPixel_t           vpPixel,
    output logic                         vpValid,
    output logic                         vpFrameStart,
    output logic [`DVP_PIXEL_CNT_W-1:0]  vpPixelCount
);
    import dvp_pkg::*;

    logic [9:0] graySum;  // r + 2g + b, at most 1020
    rgbPixel_t  s1Pixel;
    logic [7:0] s1Gray;
    logic       s1Valid;
    logic       s1FrameStart;
    rgbPixel_t  outPixel;

    assign graySum = {2'b00, viPixel.r} + {1'b0, viPixel.g, 1'b0} + {2'b00, viPixel.b};

    // Stage 1, luma estimate
    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            s1Valid      <= 1'b0;
            s1FrameStart <= 1'b0;
        end else begin
            s1Valid      <= viValid;
            s1FrameStart <= viFrameStart;
        end
    end

    always_ff @(posedge io_ahb_PCLK) begin
        s1Pixel <= viPixel;
        s1Gray  <= graySum[9:2];  // Divide by 4, truncated
    end

    // Stage 2 output select
    always_comb begin
        outPixel = s1Pixel;
        if (vpEnable) begin
            case (vpMode)
                VP_GRAY:      outPixel = {s1Gray, s1Gray, s1Gray};
                VP_THRESHOLD: outPixel = (s1Gray >= vpThreshold) ? '1 : '0;
                default: ;  // Bypass and reserved
            endcase
        end
    end

    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            vpValid      <= 1'b0;
            vpFrameStart <= 1'b0;
            vpPixelCount <= '0;
        end else begin
            vpValid      <= s1Valid;
            vpFrameStart <= s1FrameStart;
            if (s1Valid && vpEnable) vpPixelCount <= vpPixelCount + 1'b1;
        end
    end

    always_ff @(posedge io_ahb_PCLK) begin
        vpPixel <= outPixel;
    end

endmodule

// ==== logic/VideoOutput.sv ====
`timescale 1ns/1ps
`include "dvp_cfg.svh"

module VideoOutput (
    input  logic                         io_ahb_PCLK,
    input  logic                         io_ahb_PRESET,
    input  logic                         voEnable,
    input  dvp_pkg::rgbPixel_t           vpPixel,
    input  logic                         vpValid,
    input  logic                         vpFrameStart,
    output dvp_pkg::rgbPixel_t           vidPixel,
    output logic                         vidValid,
    output logic                         vidFrameStart,
    output logic [`DVP_FRAME_CNT_W-1:0]  voFrameCount
);

    logic frameOut;

    // A frame start that actually reaches the port
    assign frameOut = voEnable && vpValid && vpFrameStart;

    always_ff @(posedge io_ahb_PCLK or posedge io_ahb_PRESET) begin
        if (io_ahb_PRESET) begin
            vidValid      <= 1'b0;
            vidFrameStart <= 1'b0;
            voFrameCount  <= '0;
        end else begin
            vidValid      <= voEnable && vpValid;
            vidFrameStart <= frameOut;
            if (frameOut) begin
                voFrameCount <= voFrameCount + 1'b1;
            end
        end
    end

    // Pixel data follows the stream regardless of enable
    always_ff @(posedge io_ahb_PCLK) begin
        vidPixel <= vpPixel;
    end

endmodule

// ==== logic/DvpTop.sv ====
`timescale 1ns/1ps
`include "dvp_cfg.svh"

module DvpTop (
    input  logic                io_ahb_PCLK,
    input  logic                io_ahb_PRESET,
    input  logic [2:0]          io_ahb_PADDR,
    input  logic [0:0]          io_ahb_PSEL,
    input  logic                io_ahb_PENABLE,
    output logic                io_ahb_PREADY,
    input  logic                io_ahb_PWRITE,
    input  logic [31:0]         io_ahb_PWDATA,
    output logic [31:0]         io_ahb_PRDATA,
    output logic                io_ahb_PSLVERROR,
    input  dvp_pkg::rgbPixel_t  camPixel,
    input  logic                camValid,
    input  logic                camFrameStart,
    output dvp_pkg::rgbPixel_t  vidPixel,
    output logic                vidValid,
    output logic                vidFrameStart
);
    import dvp_pkg::*;

    // Configuration
    logic        viEnable;
    viMode_e     viMode;
    logic        viCut;
    logic [31:0] viStart;
    logic [31:0] viEnd;
    logic        vpEnable;
    vpMode_e     vpMode;
    logic [7:0]  vpThreshold;
    logic        voEnable;

    // Status counts
    logic [`DVP_FRAME_CNT_W-1:0] viFrameCount;
    logic [`DVP_PIXEL_CNT_W-1:0] vpPixelCount;
    logic [`DVP_FRAME_CNT_W-1:0] voFrameCount;

    // Stream between stages
    rgbPixel_t viPixel;
    logic      viValid;
    logic      viFrameStart;
    rgbPixel_t vpPixel;
    logic      vpValid;
    logic      vpFrameStart;

    AhbDVP u_regs (
        .io_ahb_PCLK      (io_ahb_PCLK),
        .io_ahb_PRESET    (io_ahb_PRESET),
        .io_ahb_PADDR     (io_ahb_PADDR),
        .io_ahb_PSEL      (io_ahb_PSEL),
        .io_ahb_PENABLE   (io_ahb_PENABLE),
        .io_ahb_PREADY    (io_ahb_PREADY),
        .io_ahb_PWRITE    (io_ahb_PWRITE),
        .io_ahb_PWDATA    (io_ahb_PWDATA),
        .io_ahb_PRDATA    (io_ahb_PRDATA),
        .io_ahb_PSLVERROR (io_ahb_PSLVERROR),
        .viFrameCount     (viFrameCount),
        .vpPixelCount     (vpPixelCount),
        .voFrameCount     (voFrameCount),
        .viEnable         (viEnable),
        .viMode           (viMode),
        .viCut            (viCut),
        .viStart          (viStart),
        .viEnd            (viEnd),
        .vpEnable         (vpEnable),
        .vpMode           (vpMode),
        .vpThreshold      (vpThreshold),
        .voEnable         (voEnable)
    );

    VideoInput u_vi (
        .io_ahb_PCLK   (io_ahb_PCLK),
        .io_ahb_PRESET (io_ahb_PRESET),
        .viEnable      (viEnable),
        .viMode        (viMode),
        .viCut         (viCut),
        .viStart       (viStart),
        .viEnd         (viEnd),
        .camPixel      (camPixel),
        .camValid      (camValid),
        .camFrameStart (camFrameStart),
        .viPixel       (viPixel),
        .viValid       (viValid),
        .viFrameStart  (viFrameStart),
        .viFrameCount  (viFrameCount)
    );

    PixelProcess u_vp (
        .io_ahb_PCLK   (io_ahb_PCLK),
        .io_ahb_PRESET (io_ahb_PRESET),
        .vpEnable      (vpEnable),
        .vpMode        (vpMode),
        .vpThreshold   (vpThreshold),
        .viPixel       (viPixel),
        .viValid       (viValid),
        .viFrameStart  (viFrameStart),
        .vpPixel       (vpPixel),
        .vpValid       (vpValid),
        .vpFrameStart  (vpFrameStart),
        .vpPixelCount  (vpPixelCount)
    );

    VideoOutput u_vo (
        .io_ahb_PCLK   (io_ahb_PCLK),
        .io_ahb_PRESET (io_ahb_PRESET),
        .voEnable      (voEnable),
        .vpPixel       (vpPixel),
        .vpValid       (vpValid),
        .vpFrameStart  (vpFrameStart),
        .vidPixel      (vidPixel),
        .vidValid      (vidValid),
        .vidFrameStart (vidFrameStart),
        .voFrameCount  (voFrameCount)
    );

endmodule

// ==== tests/DvpTop_sva.sv ====
`timescale 1ns/1ps

module DvpTop_sva (
    input logic       io_ahb_PCLK,
    input logic       io_ahb_PRESET,
    input logic       io_ahb_PREADY,
    input logic       io_ahb_PSLVERROR,
    input logic       camValid,
    input logic       vidValid,
    input logic       vidFrameStart,
    input logic       viEnable,
    input logic [1:0] viMode,
    input logic       viCut,
    input logic       vpEnable,
    input logic [1:0] vpMode,
    input logic       voEnable
);
    import dvp_pkg::*;

    logic plainPath;  // Camera straight through, nothing cropped or altered

    assign plainPath = viEnable && viMode == VI_CAMERA && !viCut &&
                       vpEnable && vpMode == VP_BYPASS && voEnable;

    busResponse: assert property (@(posedge io_ahb_PCLK)
        io_ahb_PREADY && !io_ahb_PSLVERROR)
        else $error("bus response not ready or flagged an error");

    startHasValid: assert property (@(posedge io_ahb_PCLK) disable iff (io_ahb_PRESET)
        vidFrameStart |-> vidValid)
        else $error("vidFrameStart without vidValid");

    outputGated: assert property (@(posedge io_ahb_PCLK) disable iff (io_ahb_PRESET)
        !voEnable |=> !vidValid)
        else $error("vidValid while output disabled");

    // Four stage registers from camera port to video port
    pathLatency: assert property (@(posedge io_ahb_PCLK) disable iff (io_ahb_PRESET)
        plainPath && camValid |-> ##4 vidValid)
        else $error("camera pixel missing at the output after 4 cycles");

endmodule

bind DvpTop DvpTop_sva u_sva (
    .io_ahb_PCLK      (io_ahb_PCLK),
    .io_ahb_PRESET    (io_ahb_PRESET),
    .io_ahb_PREADY    (io_ahb_PREADY),
    .io_ahb_PSLVERROR (io_ahb_PSLVERROR),
    .camValid         (camValid),
    .vidValid         (vidValid),
    .vidFrameStart    (vidFrameStart),
    .viEnable         (viEnable),
    .viMode           (viMode),
    .viCut            (viCut),
    .vpEnable         (vpEnable),
    .vpMode           (vpMode),
    .voEnable         (voEnable)
);

// ==== tests/DvpTop_tb.sv ====
`timescale 1ns/1ps
`include "dvp_cfg.svh"

module DvpTop_tb;
    import dvp_pkg::*;

    localparam int waitLimit = 3000;  // Cycles any single wait may take

    logic        io_ahb_PCLK;
    logic        io_ahb_PRESET;
    logic [2:0]  io_ahb_PADDR;
    logic [0:0]  io_ahb_PSEL;
    logic        io_ahb_PENABLE;
    logic        io_ahb_PREADY;
    logic        io_ahb_PWRITE;
    logic [31:0] io_ahb_PWDATA;
    logic [31:0] io_ahb_PRDATA;
    logic        io_ahb_PSLVERROR;
    rgbPixel_t   camPixel;
    logic        camValid;
    logic        camFrameStart;
    rgbPixel_t   vidPixel;
    logic        vidValid;
    logic        vidFrameStart;

    logic [31:0] lfsr = 32'h30b8_af50;
    logic [24:0] expQ[$];  // {frameStart, pixel} in output order
    logic [24:0] expWord;
    logic        mViOn;    // Camera source enabled
    logic        mCut;
    logic        mVpOn;
    vpMode_e     mVpMode;
    logic [7:0]  mThr;
    logic        mVoOn;
    int          winX0;
    int          winX1;
    int          winY0;
    int          winY1;
    int          countVi;
    int          countVp;
    int          countVo;
    logic        patMode;  // Monitor follows the test pattern instead of the queue
    int          patX;
    int          patY;
    int          patFrames;

    DvpTop u_dut (.*);

    always #50 io_ahb_PCLK = ~io_ahb_PCLK;

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [23:0] processPixel(input logic [23:0] p);
        int gray;
        gray = (int'(p[23:16]) + 2 * int'(p[15:8]) + int'(p[7:0])) / 4;
        if (!mVpOn || mVpMode == VP_BYPASS || mVpMode == VP_RESERVED) return p;
        if (mVpMode == VP_GRAY) return {3{gray[7:0]}};
        return (gray >= int'(mThr)) ? 24'hff_ffff : 24'h0;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkEqual(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("ERROR: time %0t %s got 0x%0h expected 0x%0h",
                              $time, name, got, exp));
        end
    endtask

    // One APB transfer with setup and access phases until PREADY
    task automatic busAccess(input logic write, input logic [2:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        @(negedge io_ahb_PCLK);
        io_ahb_PSEL   = 1'b1;
        io_ahb_PWRITE = write;
        io_ahb_PADDR  = addr;
        io_ahb_PWDATA = wdata;
        @(negedge io_ahb_PCLK);
        io_ahb_PENABLE = 1'b1;
        n = 0;
        do begin
            @(negedge io_ahb_PCLK);  // Access edge has passed
            rdata = io_ahb_PRDATA;
            n++;
            if (n > waitLimit) failRun("bus access never completed, PREADY stayed low");
        end while (io_ahb_PREADY !== 1'b1);
        io_ahb_PSEL    = 1'b0;
        io_ahb_PENABLE = 1'b0;
        io_ahb_PWRITE  = 1'b0;
    endtask

    task automatic busWrite(input logic [2:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        busAccess(1'b1, addr, data, ignored);
    endtask

    task automatic readCheck(input logic [2:0] addr, input logic [31:0] exp,
                             input string name);
        logic [31:0] got;
        busAccess(1'b0, addr, 32'h0, got);
        checkEqual(name, got, exp);
    endtask

    task automatic configure(input logic [31:0] viCr, input logic [31:0] vpCr,
                             input logic [31:0] voCr);
        busWrite(`DVP_ADDR_VP_CR, vpCr);
        busWrite(`DVP_ADDR_VO_CR, voCr);
        busWrite(`DVP_ADDR_VI_CR, viCr);
        mViOn   = viCr[0] && viMode_e'(viCr[2:1]) == VI_CAMERA;
        mCut    = viCr[3];
        mVpOn   = vpCr[0];
        mVpMode = vpMode_e'(vpCr[2:1]);
        mThr    = vpCr[15:8];
        mVoOn   = voCr[0];
    endtask

    // Random camera frames with idle gaps and their expected output queued
    task automatic sendFrames(input int frames);
        logic [23:0] pix;
        logic        first;
        logic        inWin;
        for (int f = 0; f < frames; f++) begin
            first = 1'b1;
            for (int y = 0; y < `DVP_FRAME_HEIGHT; y++) begin
                for (int x = 0; x < `DVP_FRAME_WIDTH; x++) begin
                    while (randBits(2) == 0) begin
                        @(negedge io_ahb_PCLK);
                        camValid      = 1'b0;
                        camFrameStart = 1'b0;
                    end
                    pix = 24'(randBits(24));
                    @(negedge io_ahb_PCLK);
                    camPixel      = rgbPixel_t'(pix);
                    camValid      = 1'b1;
                    camFrameStart = (x == 0 && y == 0);
                    inWin = !mCut || (x >= winX0 && x <= winX1 && y >= winY0 && y <= winY1);
                    if (mViOn && inWin) begin
                        if (first) countVi++;
                        if (mVpOn) countVp++;
                        if (mVoOn) begin
                            expQ.push_back({first, processPixel(pix)});
                            if (first) countVo++;
                        end
                        first = 1'b0;
                    end
                end
            end
        end
        @(negedge io_ahb_PCLK);
        camValid      = 1'b0;
        camFrameStart = 1'b0;
    endtask

    task automatic waitIdle();
        int n;
        int quiet;
        n     = 0;
        quiet = 0;
        while (expQ.size() != 0 || quiet < 6) begin
            @(negedge io_ahb_PCLK);
            quiet = vidValid ? 0 : quiet + 1;
            n++;
            if (n > waitLimit) failRun("stream did not drain, expected pixels never arrived");
        end
    endtask

    task automatic waitPattern(input int frames);
        int n;
        n = 0;
        while (patFrames < frames) begin
            @(negedge io_ahb_PCLK);
            n++;
            if (n > waitLimit) failRun("test pattern frames did not arrive in time");
        end
    endtask

    // Output monitor sampling at the falling edge
    always @(negedge io_ahb_PCLK) begin
        if (!io_ahb_PRESET && vidValid) begin
            if (patMode) begin
                checkEqual("vidPixel", {8'h0, vidPixel},
                           {8'h0, 8'(patX), 8'(patY), 8'(patX ^ patY)});
                checkEqual("vidFrameStart", 32'(vidFrameStart), 32'(patX == 0 && patY == 0));
                if (patX == 0 && patY == 0) patFrames++;
                if (patX == `DVP_FRAME_WIDTH - 1) begin
                    patX = 0;
                    patY = (patY == `DVP_FRAME_HEIGHT - 1) ? 0 : patY + 1;
                end else begin
                    patX++;
                end
            end else if (expQ.size() == 0) begin
                failRun("vidValid went high while no pixel was expected");
            end else begin
                expWord = expQ.pop_front();
                checkEqual("vidPixel", {8'h0, vidPixel}, {8'h0, expWord[23:0]});
                checkEqual("vidFrameStart", 32'(vidFrameStart), 32'(expWord[24]));
            end
        end
    end

    initial begin
        logic [31:0] regVal [8];
        logic        isStatus;
        io_ahb_PCLK    = 1'b0;
        io_ahb_PRESET  = 1'b1;
        io_ahb_PADDR   = 3'd0;
        io_ahb_PSEL    = 1'b0;
        io_ahb_PENABLE = 1'b0;
        io_ahb_PWRITE  = 1'b0;
        io_ahb_PWDATA  = 32'h0;
        camPixel       = '0;
        camValid       = 1'b0;
        camFrameStart  = 1'b0;
        {mViOn, mCut, mVpOn, mVoOn} = 4'b0;
        mVpMode    = VP_BYPASS;
        mThr       = 8'h0;
        patMode    = 1'b0;
        repeat (8) @(posedge io_ahb_PCLK);
        @(negedge io_ahb_PCLK);
        io_ahb_PRESET = 1'b0;

        for (int a = 0; a < 8; a++) readCheck(3'(a), 32'h0, "io_ahb_PRDATA");
        // Random writes to every offset with source and output enables held low
        for (int a = 0; a < 8; a++) begin
            regVal[a] = randBits(32);
            if (3'(a) == `DVP_ADDR_VI_CR || 3'(a) == `DVP_ADDR_VO_CR) regVal[a][0] = 1'b0;
            busWrite(3'(a), regVal[a]);
        end
        for (int a = 0; a < 8; a++) begin
            isStatus = 3'(a) == `DVP_ADDR_VI_SR || 3'(a) == `DVP_ADDR_VP_SR ||
                       3'(a) == `DVP_ADDR_VO_SR;
            readCheck(3'(a), isStatus ? 32'h0 : regVal[a], "io_ahb_PRDATA");
        end

        configure(32'h3, 32'h1, 32'h1);  // Camera, bypass, output on
        sendFrames(2);
        waitIdle();

        winX0 = int'(randBits(4));
        winX1 = winX0 + int'(randBits(4)) % (`DVP_FRAME_WIDTH - winX0);
        winY0 = int'(randBits(3));
        winY1 = winY0 + int'(randBits(3)) % (`DVP_FRAME_HEIGHT - winY0);
        busWrite(`DVP_ADDR_VI_START, {16'(winY0), 16'(winX0)});
        busWrite(`DVP_ADDR_VI_END, {16'(winY1), 16'(winX1)});
        configure(32'hb, 32'h1, 32'h1);
        sendFrames(2);
        waitIdle();

        configure(32'h3, 32'h5, 32'h1);  // Gray
        sendFrames(1);
        waitIdle();
        configure(32'h3, {16'h0, 8'(randBits(8)), 8'h3}, 32'h1);  // Threshold
        sendFrames(1);
        waitIdle();

        // Input disabled first and output disabled next
        configure(32'h2, 32'h1, 32'h1);
        sendFrames(1);
        waitIdle();
        configure(32'h3, 32'h1, 32'h0);
        sendFrames(1);
        waitIdle();
        readCheck(`DVP_ADDR_VI_SR, 32'(countVi), "VI_SR");
        readCheck(`DVP_ADDR_VP_SR, 32'(countVp), "VP_SR");
        readCheck(`DVP_ADDR_VO_SR, 32'(countVo), "VO_SR");

        // Generator starts at the origin after whole camera frames
        patMode = 1'b1;
        configure(32'h1, 32'h1, 32'h1);
        waitPattern(3);
        busWrite(`DVP_ADDR_VI_CR, 32'h0);
        waitIdle();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== DvpTop.f ====
+incdir+logic
logic/dvp_pkg.sv
logic/AhbDVP.sv
logic/VideoInput.sv
logic/PixelProcess.sv
logic/VideoOutput.sv
logic/DvpTop.sv
tests/DvpTop_sva.sv
tests/DvpTop_tb.sv

// ==== Makefile ====
TOP := DvpTop_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f DvpTop.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

lint:
	verilator --lint-only -Wall --timing -f DvpTop.f --top-module DvpTop

clean:
	rm -rf obj_dir
